//--- tb.f
+incdir+dv
logic/pcie_os_pkg.sv
logic/ltssm_pkg.sv
logic/ts_os_transmitter.sv
logic/ts_rx_qualifier.sv
logic/ltssm_polling.sv
logic/ltssm_polling_top.sv
dv/tb_ltssm_polling.sv

//--- dv/tb_polling_tests.svh
function automatic logic wait_met(input wait_e kind);
  case (kind)
    W_RESULT: return success_o || error_o;
    W_TS2:    return m_axis_tvalid_o && (m_axis_tuser_o.os_kind == pcie_os_pkg::TS2);
    W_IDLE:   return !m_axis_tvalid_o;
    default:  return m_axis_tvalid_o;
  endcase
endfunction

task automatic wait_until(input string what, input wait_e kind);
  int n;
  n = 0;
  do begin
    @(negedge clk_i);
    n++;
  end while (!wait_met(kind) && n < WAIT_LIMIT);
  if (!wait_met(kind)) begin
    other_errs++;
    $display("%s: gave up waiting for %s", test_name, what);
  end
endtask

// n consecutive strobes on the chosen lanes
task automatic send_ts(input logic [NUM_LANES-1:0] lanes, input pcie_os_pkg::os_kind_e kind,
                       input int n, input logic [7:0] link, input logic [7:0] lane);
  repeat (n) begin
    @(posedge clk_i);
    #2;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (lanes[i]) begin
        link_num_i[i] = link;
        lane_num_i[i] = lane;
      end
    end
    ts1_valid_i = (kind == pcie_os_pkg::TS1) ? lanes : '0;
    ts2_valid_i = (kind == pcie_os_pkg::TS2) ? lanes : '0;
  end
  @(posedge clk_i);
  #2;
  ts1_valid_i = '0;
  ts2_valid_i = '0;
endtask

task automatic open_test(input string name, input logic [NUM_LANES-1:0] detected);
  test_name = name;
  rx_data_q.delete();
  rx_last_q.delete();
  rx_keep_q.delete();
  rx_user_q.delete();
  @(posedge clk_i);
  #2;
  receiver_detected_i = detected;
  link_num_i = {NUM_LANES{pcie_os_pkg::PAD_SYM}};
  lane_num_i = {NUM_LANES{pcie_os_pkg::PAD_SYM}};
  en_i = 1'b1;
  wait_until("first word", W_TX);
endtask

// TS1 sets first, TS2 only from a set boundary on
task automatic check_stream(input logic ts2_expected);
  pcie_os_pkg::os_kind_e  kind;
  pcie_os_pkg::phy_user_t exp_user;
  int                     ts1_sets;
  kind = pcie_os_pkg::TS1;
  ts1_sets = 0;
  check_flag("whole sets", 1'b1, (rx_data_q.size() % 4) == 0);
  foreach (rx_data_q[i]) begin
    if ((i % 4) == 0 && ts2_expected && kind == pcie_os_pkg::TS1 &&
        rx_user_q[i].os_kind == pcie_os_pkg::TS2) begin
      kind = pcie_os_pkg::TS2;
      check_flag("enough TS1 sets", 1'b1, ts1_sets >= MIN_TS1_SETS);
    end
    if ((i % 4) == 0 && kind == pcie_os_pkg::TS1) begin
      ts1_sets++;
    end
    exp_user = '0;
    exp_user.is_os = 1'b1;
    exp_user.os_kind = kind;
    check_word("tdata", expected_word(kind, i % 4), rx_data_q[i]);
    check_word("tkeep", 32'hf, {28'h0, rx_keep_q[i]});
    check_flag("tlast", (i % 4) == 3, rx_last_q[i]);
    check_user("tuser", exp_user, rx_user_q[i]);
  end
  check_flag("TS2 sent", ts2_expected, kind == pcie_os_pkg::TS2);
endtask

task automatic close_test(input logic exp_success, input logic ts2_expected);
  wait_until("result", W_RESULT);
  check_flag("success", exp_success, success_o);
  check_flag("error", !exp_success, error_o);
  wait_until("stream idle", W_IDLE);
  check_stream(ts2_expected);
  @(posedge clk_i);
  #2;
  en_i = 1'b0;
  repeat (2) @(negedge clk_i);
  check_flag("success cleared", 1'b0, success_o);
  check_flag("error cleared", 1'b0, error_o);
  check_flag("tvalid low", 1'b0, m_axis_tvalid_o);
endtask

task automatic test_idle_after_reset();
  test_name = "idle_after_reset";
  repeat (40) begin
    @(negedge clk_i);
    check_flag("tvalid", 1'b0, m_axis_tvalid_o);
    check_flag("success", 1'b0, success_o);
    check_flag("error", 1'b0, error_o);
  end
  check_flag("no words", 1'b1, rx_data_q.size() == 0);
endtask

// no strobes, so Active ends in error after the TS1 sets
task automatic test_ts1_framing();
  open_test("ts1_framing", '1);
  close_test(1'b0, 1'b0);
endtask

task automatic test_full_success();
  open_test("full_success", '1);
  send_ts('1, pcie_os_pkg::TS1, REQ_CONSEC_TS, pcie_os_pkg::PAD_SYM, pcie_os_pkg::PAD_SYM);
  wait_until("first TS2 word", W_TS2);
  send_ts('1, pcie_os_pkg::TS2, REQ_CONSEC_TS, pcie_os_pkg::PAD_SYM, pcie_os_pkg::PAD_SYM);
  close_test(1'b1, 1'b1);
endtask

task automatic test_undetected_lane();
  open_test("undetected_lane", 4'b1011);
  send_ts(4'b1011, pcie_os_pkg::TS1, REQ_CONSEC_TS, pcie_os_pkg::PAD_SYM,
          pcie_os_pkg::PAD_SYM);
  wait_until("first TS2 word", W_TS2);
  send_ts(4'b1011, pcie_os_pkg::TS2, REQ_CONSEC_TS, pcie_os_pkg::PAD_SYM,
          pcie_os_pkg::PAD_SYM);
  close_test(1'b1, 1'b1);
endtask

task automatic test_active_failure();
  open_test("active_failure", '1);
  send_ts(4'b1101, pcie_os_pkg::TS1, REQ_CONSEC_TS, pcie_os_pkg::PAD_SYM,
          pcie_os_pkg::PAD_SYM);
  // lane 1 carries a real link number
  send_ts(4'b0010, pcie_os_pkg::TS1, REQ_CONSEC_TS, 8'h00, pcie_os_pkg::PAD_SYM);
  close_test(1'b0, 1'b0);
endtask

task automatic test_config_timeout();
  pcie_os_pkg::phy_user_t ts2_user;
  ts2_user = '0;
  ts2_user.is_os = 1'b1;
  ts2_user.os_kind = pcie_os_pkg::TS2;
  open_test("config_timeout", '1);
  send_ts('1, pcie_os_pkg::TS1, REQ_CONSEC_TS, pcie_os_pkg::PAD_SYM, pcie_os_pkg::PAD_SYM);
  wait_until("first TS2 word", W_TS2);
  send_ts('1, pcie_os_pkg::TS2, REQ_CONSEC_TS, pcie_os_pkg::PAD_SYM, 8'h01);
  wait_until("result", W_RESULT);
  check_user("word before error", ts2_user, rx_user_q[$]);
  close_test(1'b0, 1'b1);
endtask

//--- dv/tb_ltssm_polling.sv
`timescale 1ns/1ps

module tb_ltssm_polling;

  localparam int NUM_LANES = 4;
  localparam int ACTIVE_TIMEOUT = 2000;
  localparam int CONFIG_TIMEOUT = 4000;
  localparam int MIN_TS1_SETS = 16;
  localparam int REQ_CONSEC_TS = 8;
  localparam int N_FTS = 8;
  localparam int CLK_PERIOD = 20;
  localparam int NUM_TESTS = 6;
  localparam int WAIT_LIMIT = ACTIVE_TIMEOUT + CONFIG_TIMEOUT + 400;
  localparam int WATCHDOG_NS = (ACTIVE_TIMEOUT + CONFIG_TIMEOUT) * NUM_TESTS * 2 * CLK_PERIOD;

  typedef enum {W_RESULT, W_TS2, W_IDLE, W_TX} wait_e;

  logic                      clk_i;
  logic                      rst_i;
  logic                      en_i;
  logic                      success_o;
  logic                      error_o;
  logic [NUM_LANES-1:0]      receiver_detected_i;
  logic [NUM_LANES-1:0]      ts1_valid_i;
  logic [NUM_LANES-1:0]      ts2_valid_i;
  logic [NUM_LANES-1:0][7:0] link_num_i;
  logic [NUM_LANES-1:0][7:0] lane_num_i;
  logic [31:0]               m_axis_tdata_o;
  logic [3:0]                m_axis_tkeep_o;
  logic                      m_axis_tvalid_o;
  logic                      m_axis_tlast_o;
  pcie_os_pkg::phy_user_t    m_axis_tuser_o;
  logic                      m_axis_tready_i;

  string                  test_name = "reset";
  logic                   random_ready = 1'b0;
  int                     word_errs = 0;
  int                     user_errs = 0;
  int                     flag_errs = 0;
  int                     other_errs = 0;
  int                     seed_init;
  logic                   stalled = 1'b0;
  logic [31:0]            held_data;
  // words accepted on the stream
  logic [31:0]            rx_data_q[$];
  logic                   rx_last_q[$];
  logic [3:0]             rx_keep_q[$];
  pcie_os_pkg::phy_user_t rx_user_q[$];

  ltssm_polling_top #(
    .NUM_LANES      (NUM_LANES),
    .ACTIVE_TIMEOUT (ACTIVE_TIMEOUT),
    .CONFIG_TIMEOUT (CONFIG_TIMEOUT),
    .MIN_TS1_SETS   (MIN_TS1_SETS),
    .REQ_CONSEC_TS  (REQ_CONSEC_TS),
    .N_FTS          (N_FTS)
  ) u_ltssm_polling_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    #2;
    m_axis_tready_i = random_ready ? (($urandom % 2) != 0) : 1'b1;
  end

  // sampled at the falling edge, where the next handshake is settled
  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (stalled) begin
        check_flag("held word valid", 1'b1, m_axis_tvalid_o);
        check_word("held word data", held_data, m_axis_tdata_o);
      end
      stalled = m_axis_tvalid_o && !m_axis_tready_i;
      held_data = m_axis_tdata_o;
      if (m_axis_tvalid_o && m_axis_tready_i) begin
        rx_data_q.push_back(m_axis_tdata_o);
        rx_last_q.push_back(m_axis_tlast_o);
        rx_keep_q.push_back(m_axis_tkeep_o);
        rx_user_q.push_back(m_axis_tuser_o);
      end
    end
  end

  task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      word_errs++;
      $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_user(input string what, input pcie_os_pkg::phy_user_t exp,
                            input pcie_os_pkg::phy_user_t act);
    if (act !== exp) begin
      user_errs++;
      $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      flag_errs++;
      $display("[FAIL] %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  // symbol n of the set sits in byte n mod 4 of word n / 4
  function automatic logic [31:0] expected_word(input pcie_os_pkg::os_kind_e kind, input int idx);
    logic [7:0] sym [16];
    logic [7:0] id;
    id = (kind == pcie_os_pkg::TS2) ? pcie_os_pkg::TS2_ID_SYM : pcie_os_pkg::TS1_ID_SYM;
    sym[0] = pcie_os_pkg::COM_SYM;
    sym[1] = pcie_os_pkg::PAD_SYM;
    sym[2] = pcie_os_pkg::PAD_SYM;
    sym[3] = 8'(N_FTS);
    sym[4] = 8'h02;
    sym[5] = 8'h00;
    for (int i = 6; i < 16; i++) begin
      sym[i] = id;
    end
    return {sym[4*idx+3], sym[4*idx+2], sym[4*idx+1], sym[4*idx]};
  endfunction

  `include "tb_polling_tests.svh"

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests completed");
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin : main
    seed_init = $urandom(62388);
    rst_i = 1'b1;
    en_i = 1'b0;
    receiver_detected_i = '0;
    ts1_valid_i = '0;
    ts2_valid_i = '0;
    link_num_i = {NUM_LANES{pcie_os_pkg::PAD_SYM}};
    lane_num_i = {NUM_LANES{pcie_os_pkg::PAD_SYM}};
    m_axis_tready_i = 1'b0;
    repeat (16) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    random_ready = 1'b1;
    test_idle_after_reset();
    test_ts1_framing();
    test_full_success();
    test_undetected_lane();
    test_active_failure();
    test_config_timeout();
    $display("errors: word %0d, user %0d, flag %0d, other %0d",
             word_errs, user_errs, flag_errs, other_errs);
    if (word_errs + user_errs + flag_errs + other_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- logic/ltssm_polling_top.sv
`timescale 1ns/1ps

module ltssm_polling_top #(
  parameter int NUM_LANES = 4,
  parameter int ACTIVE_TIMEOUT = 24_000_000,
  parameter int CONFIG_TIMEOUT = 48_000_000,
  parameter int MIN_TS1_SETS = 1024,
  parameter int REQ_CONSEC_TS = 8,
  parameter int N_FTS = 8,
  localparam int DATA_WIDTH = 32,
  localparam int KEEP_WIDTH = DATA_WIDTH / 8
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      en_i,
  output logic                      success_o,
  output logic                      error_o,
  input  logic [NUM_LANES-1:0]      receiver_detected_i,
  input  logic [NUM_LANES-1:0]      ts1_valid_i,
  input  logic [NUM_LANES-1:0]      ts2_valid_i,
  input  logic [NUM_LANES-1:0][7:0] link_num_i,
  input  logic [NUM_LANES-1:0][7:0] lane_num_i,
  output logic [DATA_WIDTH-1:0]     m_axis_tdata_o,
  output logic [KEEP_WIDTH-1:0]     m_axis_tkeep_o,
  output logic                      m_axis_tvalid_o,
  output logic                      m_axis_tlast_o,
  output pcie_os_pkg::phy_user_t    m_axis_tuser_o,
  input  logic                      m_axis_tready_i
);

  logic                  tx_en;
  pcie_os_pkg::os_kind_e tx_kind;
  logic                  set_done;
  ltssm_pkg::rx_phase_e  rx_phase;
  logic                  rx_clear;
  logic [NUM_LANES-1:0]  lanes_satisfied;

  ltssm_polling #(
    .NUM_LANES      (NUM_LANES),
    .ACTIVE_TIMEOUT (ACTIVE_TIMEOUT),
    .CONFIG_TIMEOUT (CONFIG_TIMEOUT),
    .MIN_TS1_SETS   (MIN_TS1_SETS)
  ) u_ltssm_polling (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .en_i              (en_i),
    .lanes_satisfied_i (lanes_satisfied),
    .set_done_i        (set_done),
    .tx_en_o           (tx_en),
    .tx_kind_o         (tx_kind),
    .rx_phase_o        (rx_phase),
    .rx_clear_o        (rx_clear),
    .success_o         (success_o),
    .error_o           (error_o)
  );

  ts_os_transmitter #(
    .N_FTS (N_FTS)
  ) u_ts_os_transmitter (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .tx_en_i         (tx_en),
    .tx_kind_i       (tx_kind),
    .m_axis_tdata_o  (m_axis_tdata_o),
    .m_axis_tkeep_o  (m_axis_tkeep_o),
    .m_axis_tvalid_o (m_axis_tvalid_o),
    .m_axis_tlast_o  (m_axis_tlast_o),
    .m_axis_tuser_o  (m_axis_tuser_o),
    .m_axis_tready_i (m_axis_tready_i),
    .set_done_o      (set_done)
  );

  ts_rx_qualifier #(
    .NUM_LANES     (NUM_LANES),
    .REQ_CONSEC_TS (REQ_CONSEC_TS)
  ) u_ts_rx_qualifier (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .phase_i             (rx_phase),
    .clear_i             (rx_clear),
    .receiver_detected_i (receiver_detected_i),
    .ts1_valid_i         (ts1_valid_i),
    .ts2_valid_i         (ts2_valid_i),
    .link_num_i          (link_num_i),
    .lane_num_i          (lane_num_i),
    .lanes_satisfied_o   (lanes_satisfied)
  );

endmodule

//--- logic/ltssm_polling.sv
`timescale 1ns/1ps

module ltssm_polling #(
  parameter int NUM_LANES = 4,
  parameter int ACTIVE_TIMEOUT = 24_000_000,
  parameter int CONFIG_TIMEOUT = 48_000_000,
  parameter int MIN_TS1_SETS = 1024
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  en_i,
  input  logic [NUM_LANES-1:0]  lanes_satisfied_i,
  input  logic                  set_done_i,
  output logic                  tx_en_o,
  output pcie_os_pkg::os_kind_e tx_kind_o,
  output ltssm_pkg::rx_phase_e  rx_phase_o,
  output logic                  rx_clear_o,
  output logic                  success_o,
  output logic                  error_o
);

  localparam int ACT_WIDTH = $clog2(ACTIVE_TIMEOUT + 1);
  localparam int CFG_WIDTH = $clog2(CONFIG_TIMEOUT + 1);
  localparam int SENT_WIDTH = $clog2(MIN_TS1_SETS + 1);
  localparam logic [ACT_WIDTH-1:0] ACT_MAX = ACT_WIDTH'(ACTIVE_TIMEOUT);
  localparam logic [CFG_WIDTH-1:0] CFG_MAX = CFG_WIDTH'(CONFIG_TIMEOUT);
  localparam logic [SENT_WIDTH-1:0] SENT_MAX = SENT_WIDTH'(MIN_TS1_SETS);

  ltssm_pkg::polling_state_e state_r, state_c;
  logic [ACT_WIDTH-1:0]      active_timer_r, active_timer_c;
  logic [CFG_WIDTH-1:0]      config_timer_r, config_timer_c;
  logic [SENT_WIDTH-1:0]     ts1_sent_r, ts1_sent_c;
  logic                      success_r, success_c;
  logic                      error_r, error_c;
  logic                      rx_clear_r, rx_clear_c;

  logic [ACT_WIDTH-1:0]      active_timer_inc;
  logic [CFG_WIDTH-1:0]      config_timer_inc;
  logic [SENT_WIDTH-1:0]     ts1_sent_inc;
  logic                      all_satisfied;
  logic                      active_done;

  // saturating increments
  assign active_timer_inc = (active_timer_r == ACT_MAX) ? active_timer_r : active_timer_r + 1'b1;
  assign config_timer_inc = (config_timer_r == CFG_MAX) ? config_timer_r : config_timer_r + 1'b1;
  assign ts1_sent_inc     = (ts1_sent_r == SENT_MAX) ? ts1_sent_r : ts1_sent_r + 1'b1;

  assign all_satisfied = &lanes_satisfied_i;
  // counts the set that is finishing now
  assign active_done   = (active_timer_r == ACT_MAX) || (ts1_sent_inc == SENT_MAX);

  always_ff @(posedge clk_i or posedge rst_i) begin : main_seq
    if (rst_i) begin
      state_r        <= ltssm_pkg::ST_IDLE;
      active_timer_r <= '0;
      config_timer_r <= '0;
      ts1_sent_r     <= '0;
      success_r      <= 1'b0;
      error_r        <= 1'b0;
      rx_clear_r     <= 1'b0;
    end else begin
      state_r        <= state_c;
      active_timer_r <= active_timer_c;
      config_timer_r <= config_timer_c;
      ts1_sent_r     <= ts1_sent_c;
      success_r      <= success_c;
      error_r        <= error_c;
      rx_clear_r     <= rx_clear_c;
    end
  end

  always_comb begin : main_comb
    state_c        = state_r;
    active_timer_c = active_timer_r;
    config_timer_c = config_timer_r;
    ts1_sent_c     = ts1_sent_r;
    success_c      = success_r;
    error_c        = error_r;
    rx_clear_c     = 1'b0;

    case (state_r)
      ltssm_pkg::ST_IDLE: begin
        if (en_i) begin
          state_c        = ltssm_pkg::ST_POLLING_ACTIVE;
          active_timer_c = '0;
          ts1_sent_c     = '0;
        end
      end
      ltssm_pkg::ST_POLLING_ACTIVE: begin
        active_timer_c = active_timer_inc;
        // decisions only at set boundaries
        if (set_done_i) begin
          ts1_sent_c = ts1_sent_inc;
          if (active_done) begin
            if (all_satisfied) begin
              state_c        = ltssm_pkg::ST_POLLING_CONFIGURATION;
              config_timer_c = '0;
              rx_clear_c     = 1'b1;
            end else begin
              // would be Polling.Compliance
              error_c = 1'b1;
              state_c = ltssm_pkg::ST_WAIT_EN_LOW;
            end
          end
        end
      end
      ltssm_pkg::ST_POLLING_CONFIGURATION: begin
        config_timer_c = config_timer_inc;
        if (set_done_i) begin
          if (all_satisfied) begin
            success_c = 1'b1;
            state_c   = ltssm_pkg::ST_WAIT_EN_LOW;
          end else if (config_timer_r == CFG_MAX) begin
            error_c = 1'b1;
            state_c = ltssm_pkg::ST_WAIT_EN_LOW;
          end
        end
      end
      ltssm_pkg::ST_WAIT_EN_LOW: begin
        if (!en_i) begin
          state_c   = ltssm_pkg::ST_IDLE;
          success_c = 1'b0;
          error_c   = 1'b0;
        end
      end
      default: begin
        state_c = ltssm_pkg::ST_IDLE;
      end
    endcase
  end

  assign tx_en_o = (state_r == ltssm_pkg::ST_POLLING_ACTIVE) ||
                   (state_r == ltssm_pkg::ST_POLLING_CONFIGURATION);
  assign tx_kind_o = (state_r == ltssm_pkg::ST_POLLING_CONFIGURATION) ?
                     pcie_os_pkg::TS2 : pcie_os_pkg::TS1;

  always_comb begin : phase_comb
    case (state_r)
      ltssm_pkg::ST_POLLING_ACTIVE:        rx_phase_o = ltssm_pkg::PH_ACTIVE;
      ltssm_pkg::ST_POLLING_CONFIGURATION: rx_phase_o = ltssm_pkg::PH_CONFIG;
      default:                             rx_phase_o = ltssm_pkg::PH_OFF;
    endcase
  end

  assign rx_clear_o = rx_clear_r;
  assign success_o  = success_r;
  assign error_o    = error_r;

  result_exclusive_a : assert property (
    @(posedge clk_i) disable iff (rst_i)
    !(success_o && error_o)
  ) else $error("success and error both reported");

endmodule

//--- logic/ts_rx_qualifier.sv
`timescale 1ns/1ps

module ts_rx_qualifier #(
  parameter int NUM_LANES = 4,
  parameter int REQ_CONSEC_TS = 8
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  ltssm_pkg::rx_phase_e       phase_i,
  input  logic                       clear_i,
  input  logic [NUM_LANES-1:0]       receiver_detected_i,
  input  logic [NUM_LANES-1:0]       ts1_valid_i,
  input  logic [NUM_LANES-1:0]       ts2_valid_i,
  input  logic [NUM_LANES-1:0][7:0]  link_num_i,
  input  logic [NUM_LANES-1:0][7:0]  lane_num_i,
  output logic [NUM_LANES-1:0]       lanes_satisfied_o
);

  localparam int CNT_WIDTH = $clog2(REQ_CONSEC_TS + 1);
  localparam logic [CNT_WIDTH-1:0] CNT_MAX = CNT_WIDTH'(REQ_CONSEC_TS);

  for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
    logic [CNT_WIDTH-1:0] consec_cnt;
    logic                 pad_ok;
    logic                 any_ts;
    logic                 good_ts;

    assign pad_ok = (link_num_i[i] == pcie_os_pkg::PAD_SYM) &&
                    (lane_num_i[i] == pcie_os_pkg::PAD_SYM);
    assign any_ts = ts1_valid_i[i] || ts2_valid_i[i];

    // in Configuration only TS2 counts
    always_comb begin
      good_ts = 1'b0;
      case (phase_i)
        ltssm_pkg::PH_ACTIVE: good_ts = any_ts && pad_ok;
        ltssm_pkg::PH_CONFIG: good_ts = ts2_valid_i[i] && pad_ok;
        default:              good_ts = 1'b0;
      endcase
    end

    always_ff @(posedge clk_i or posedge rst_i) begin : cnt_seq
      if (rst_i) begin
        consec_cnt <= '0;
      end else if (clear_i || (phase_i == ltssm_pkg::PH_OFF)) begin
        consec_cnt <= '0;
      end else if (good_ts) begin
        if (consec_cnt != CNT_MAX) begin
          consec_cnt <= consec_cnt + 1'b1;
        end
      end else if (any_ts) begin
        // a bad set breaks the run
        consec_cnt <= '0;
      end
    end

    // nothing attached, nothing to wait for
    assign lanes_satisfied_o[i] = !receiver_detected_i[i] || (consec_cnt == CNT_MAX);
  end

  ts_strobe_onehot_a : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (ts1_valid_i & ts2_valid_i) == '0
  ) else $error("TS1 and TS2 strobed together on one lane");

endmodule

//--- logic/ts_os_transmitter.sv
`timescale 1ns/1ps

module ts_os_transmitter #(
  parameter int N_FTS = 8,
  localparam int DATA_WIDTH = 32,
  localparam int KEEP_WIDTH = DATA_WIDTH / 8
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   tx_en_i,
  input  pcie_os_pkg::os_kind_e  tx_kind_i,
  output logic [DATA_WIDTH-1:0]  m_axis_tdata_o,
  output logic [KEEP_WIDTH-1:0]  m_axis_tkeep_o,
  output logic                   m_axis_tvalid_o,
  output logic                   m_axis_tlast_o,
  output pcie_os_pkg::phy_user_t m_axis_tuser_o,
  input  logic                   m_axis_tready_i,
  output logic                   set_done_o
);

  localparam int CNT_WIDTH = $clog2(pcie_os_pkg::OS_WORDS);
  localparam int OS_BYTES = $bits(pcie_os_pkg::ts_image_t) / 8;
  localparam logic [CNT_WIDTH-1:0] LAST_WORD = CNT_WIDTH'(pcie_os_pkg::OS_WORDS - 1);
  // 2.5 GT/s only
  localparam logic [7:0] RATE_SYM = 8'h02;
  localparam pcie_os_pkg::training_ctrl_t TX_CTRL = '0;

  logic [CNT_WIDTH-1:0]   word_cnt_r;
  pcie_os_pkg::os_kind_e  kind_r;
  pcie_os_pkg::os_kind_e  cur_kind;
  pcie_os_pkg::ts_image_t image;
  logic                   last_word;
  logic                   load;

  function automatic pcie_os_pkg::ts_image_t build_image(input pcie_os_pkg::os_kind_e kind);
    pcie_os_pkg::ts_image_t img;
    logic [7:0]             id_sym;
    id_sym = (kind == pcie_os_pkg::TS2) ? pcie_os_pkg::TS2_ID_SYM : pcie_os_pkg::TS1_ID_SYM;
    img[0] = pcie_os_pkg::COM_SYM;
    // link and lane numbers not yet assigned in polling
    img[1] = pcie_os_pkg::PAD_SYM;
    img[2] = pcie_os_pkg::PAD_SYM;
    img[3] = 8'(N_FTS);
    img[4] = RATE_SYM;
    img[5] = TX_CTRL;
    for (int i = 6; i < OS_BYTES; i++) begin
      img[i] = id_sym;
    end
    return img;
  endfunction

  // kind is latched on word 0 so a set never mixes TS1 and TS2
  assign cur_kind  = (word_cnt_r == '0) ? tx_kind_i : kind_r;
  assign image     = build_image(cur_kind);
  assign last_word = (word_cnt_r == LAST_WORD);
  assign load      = tx_en_i && (m_axis_tready_i || !m_axis_tvalid_o);
  assign set_done_o = load && last_word;

  assign m_axis_tkeep_o = '1;

  always_ff @(posedge clk_i or posedge rst_i) begin : ctrl_seq
    if (rst_i) begin
      m_axis_tvalid_o <= 1'b0;
      word_cnt_r      <= '0;
      kind_r          <= pcie_os_pkg::TS1;
    end else begin
      if (load) begin
        m_axis_tvalid_o <= 1'b1;
        word_cnt_r      <= last_word ? '0 : word_cnt_r + 1'b1;
        if (word_cnt_r == '0) begin
          kind_r <= tx_kind_i;
        end
      end else if (m_axis_tready_i) begin
        // disabled, held word has gone out
        m_axis_tvalid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin : data_seq
    if (load) begin
      m_axis_tdata_o <= image[KEEP_WIDTH*word_cnt_r +: KEEP_WIDTH];
      m_axis_tlast_o <= last_word;
      m_axis_tuser_o <= '{reserved: '0, os_kind: cur_kind, is_os: 1'b1};
    end
  end

  tdata_hold_a : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (m_axis_tvalid_o && !m_axis_tready_i) |=> (m_axis_tvalid_o && $stable(m_axis_tdata_o))
  ) else $error("tdata changed while stalled");

endmodule

//--- logic/ltssm_pkg.sv
package ltssm_pkg;

  // compliance and speed substates not present
  typedef enum logic [4:0] {
    ST_IDLE,
    ST_POLLING_ACTIVE,
    ST_POLLING_CONFIGURATION,
    ST_WAIT_EN_LOW
  } polling_state_e;

  // which sets the receive qualifier counts
  typedef enum logic [1:0] {
    PH_OFF,
    PH_ACTIVE,
    PH_CONFIG
  } rx_phase_e;

endpackage

//--- logic/pcie_os_pkg.sv
package pcie_os_pkg;

  // 8b/10b control symbols, data byte values
  localparam logic [7:0] COM_SYM = 8'hBC;
  localparam logic [7:0] PAD_SYM = 8'hF7;

  // training set identifier symbols
  localparam logic [7:0] TS1_ID_SYM = 8'h4A;
  localparam logic [7:0] TS2_ID_SYM = 8'h45;

  typedef enum logic {
    TS1,
    TS2
  } os_kind_e;

  // stream words per ordered set
  localparam int OS_WORDS = 4;

  // byte 0 is the comma, byte 15 the last identifier
  typedef logic [OS_WORDS*4-1:0][7:0] ts_image_t;

  // symbol 5 of a training set
  typedef struct packed {
    logic [2:0] reserved;
    logic       compliance_receive;
    logic       disable_scrambling;
    logic       loopback;
    logic       disable_link;
    logic       hot_reset;
  } training_ctrl_t;

  // stream sideband, bit 0 flags an ordered set
  typedef struct packed {
    logic [5:0] reserved;
    os_kind_e   os_kind;
    logic       is_os;
  } phy_user_t;

endpackage
